// ==== include/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Datapath width of the execute stage
`define EX_DATA_W 16

// Issue buffer entries, also the credits a sender holds after reset
`define EX_IN_DEPTH 4

// Result slots held by the consumer
`define EX_OUT_CREDITS 2

// Immediate field widths taken from the instruction word
`define EX_IMM5_W 5
`define EX_IMM8_W 8
`define EX_IMM11_W 11

`endif

// ==== logic/ex_pkg.sv ====
`include "ex_defines.svh"

package ex_pkg;

    // Opcode lives in instruction[15:11]; low two bits pick the variant within a group
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_BTR   = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b10011,
        OP_ROL   = 5'b10100,
        OP_SLL   = 5'b10101,
        OP_ROR   = 5'b10110,
        OP_SRL   = 5'b10111,
        OP_ADD   = 5'b11000,
        OP_SUB   = 5'b11001,
        OP_XOR   = 5'b11010,
        OP_ANDN  = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } ex_opcode_e;

    typedef enum logic [2:0] {
        ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL, ALU_ADD, ALU_OR, ALU_XOR, ALU_ANDN
    } alu_op_e;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_SHIFT8, SRC_A_BITREV, SRC_A_ILLEGAL} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_ZERO, SRC_B_ILLEGAL} src_b_e;
    typedef enum logic [1:0] {PC_SEQUENTIAL, PC_BRANCH, PC_JUMP, PC_REGISTER} pc_sel_e;
    typedef enum logic [1:0] {SET_EQ, SET_LT, SET_LE, SET_CARRY} set_sel_e;
    typedef enum logic [1:0] {BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cond_e;

    typedef struct packed {
        alu_op_e  alu_op;
        src_a_e   src_a;
        src_b_e   src_b;
        pc_sel_e  pc_sel;
        set_sel_e set_sel;
        br_cond_e br_cond;
        logic     res_sel;    // Take the set result instead of the ALU result
        logic     cin;
        logic     inv_a;
        logic     inv_b;
        logic     signed_cmp;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0] instruction;
        logic [`EX_DATA_W-1:0] pc_plus;
        logic [`EX_DATA_W-1:0] reg1_data;
        logic [`EX_DATA_W-1:0] reg2_data;
    } issue_pkt_t;

    typedef struct packed {
        logic [`EX_DATA_W-1:0] alu_out;
        logic [`EX_DATA_W-1:0] pc_next;
        logic                  flush;
    } result_pkt_t;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu
    import ex_pkg::*;
(
    input  logic [`EX_DATA_W-1:0] a,
    input  logic [`EX_DATA_W-1:0] b,
    input  logic                  cin,
    input  logic                  inv_a,
    input  logic                  inv_b,
    input  logic                  signed_cmp,
    input  alu_op_e               op,
    output logic [`EX_DATA_W-1:0] result,
    output logic                  zero,
    output logic                  lt_zero,
    output logic                  cout,
    output logic                  sle_lt_zero
);

    localparam int W = `EX_DATA_W;
    localparam int SH_W = $clog2(W);

    logic [W-1:0]   a_eff;
    logic [W-1:0]   b_eff;
    logic [W-1:0]   sum;
    logic [2*W-1:0] rot_l;
    logic [2*W-1:0] rot_r;
    logic [SH_W-1:0] sh_amt;
    logic           overflow;

    assign a_eff  = inv_a ? ~a : a;
    assign b_eff  = inv_b ? ~b : b;
    assign sh_amt = b_eff[SH_W-1:0];

    assign {cout, sum} = {1'b0, a_eff} + {1'b0, b_eff} + {{W{1'b0}}, cin};

    // Signed overflow when both addends agree in sign and the sum does not
    assign overflow = (a_eff[W-1] == b_eff[W-1]) && (sum[W-1] != a_eff[W-1]);

    // With inv_b and cin set this is a < b for the compare ops
    assign sle_lt_zero = signed_cmp ? (sum[W-1] ^ overflow) : ~cout;

    // Doubled operand lets one shifter produce both rotate directions
    assign rot_l = {a_eff, a_eff} << sh_amt;
    assign rot_r = {a_eff, a_eff} >> sh_amt;

    always_comb begin
        case (op)
            ALU_ROL:  result = rot_l[2*W-1:W];
            ALU_SLL:  result = a_eff << sh_amt;
            ALU_ROR:  result = rot_r[W-1:0];
            ALU_SRL:  result = a_eff >> sh_amt;
            ALU_ADD:  result = sum;
            ALU_OR:   result = (a_eff & {W{cin}}) | b_eff;  // A joins only with cin, LBI passes B
            ALU_XOR:  result = a_eff ^ b_eff;
            ALU_ANDN: result = a_eff & ~b_eff;
            default:  result = sum;
        endcase
    end

    assign zero    = (result == '0);
    assign lt_zero = result[W-1];

endmodule

// ==== logic/branch_control.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module branch_control
    import ex_pkg::*;
(
    input  br_cond_e              br_cond,
    input  logic                  branch,
    input  logic                  alu_z,
    input  logic                  alu_ltz,
    input  logic [`EX_DATA_W-1:0] pc_plus,
    input  logic [`EX_DATA_W-1:0] branch_offset,
    output logic [`EX_DATA_W-1:0] branch_address
);

    logic cond_met;

    // Flags come from Rs+0, so they describe Rs itself
    always_comb begin
        case (br_cond)
            BR_EQZ:  cond_met = alu_z;
            BR_NEZ:  cond_met = ~alu_z;
            BR_LTZ:  cond_met = alu_ltz;
            BR_GEZ:  cond_met = ~alu_ltz;
            default: cond_met = 1'b0;
        endcase
    end

    assign branch_address = (branch && cond_met) ? pc_plus + branch_offset : pc_plus;

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module instr_decode
    import ex_pkg::*;
(
    input  logic [`EX_DATA_W-1:0] instruction,
    output ex_ctrl_t              ctrl,
    output logic [`EX_DATA_W-1:0] imm_ext
);

    localparam int W = `EX_DATA_W;

    ex_opcode_e   opcode;
    logic [W-1:0] imm5_ext;
    logic [W-1:0] imm8_ext;
    logic [W-1:0] imm11_ext;

    assign opcode = ex_opcode_e'(instruction[W-1:W-5]);

    assign imm5_ext  = {{(W-`EX_IMM5_W){instruction[`EX_IMM5_W-1]}},
                        instruction[`EX_IMM5_W-1:0]};
    assign imm8_ext  = {{(W-`EX_IMM8_W){instruction[`EX_IMM8_W-1]}},
                        instruction[`EX_IMM8_W-1:0]};
    assign imm11_ext = {{(W-`EX_IMM11_W){instruction[`EX_IMM11_W-1]}},
                        instruction[`EX_IMM11_W-1:0]};

    always_comb begin
        // NOP controls, also used for unknown opcodes
        ctrl.alu_op     = ALU_ADD;
        ctrl.src_a      = SRC_A_REG;
        ctrl.src_b      = SRC_B_ZERO;
        ctrl.pc_sel     = PC_SEQUENTIAL;
        ctrl.set_sel    = SET_EQ;
        ctrl.br_cond    = BR_EQZ;
        ctrl.res_sel    = 1'b0;
        ctrl.cin        = 1'b0;
        ctrl.inv_a      = 1'b0;
        ctrl.inv_b      = 1'b0;
        ctrl.signed_cmp = 1'b0;
        imm_ext         = imm5_ext;

        case (opcode)
            OP_ADD, OP_SUB, OP_XOR, OP_ANDN,
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                ctrl.src_b = opcode[4] ? SRC_B_REG : SRC_B_IMM;
                case (opcode[1:0])
                    2'b00: ctrl.alu_op = ALU_ADD;
                    2'b01: begin
                        ctrl.inv_a = 1'b1;  // Second operand minus Rs
                        ctrl.cin   = 1'b1;
                    end
                    2'b10: ctrl.alu_op = ALU_XOR;
                    default: ctrl.alu_op = ALU_ANDN;
                endcase
            end
            OP_ROL, OP_SLL, OP_ROR, OP_SRL: begin
                ctrl.alu_op = alu_op_e'({1'b0, opcode[1:0]});
                ctrl.src_b  = SRC_B_REG;
            end
            OP_BTR: ctrl.src_a = SRC_A_BITREV;
            OP_SLBI: begin
                ctrl.src_a = SRC_A_SHIFT8;
                imm_ext    = imm8_ext;
            end
            OP_LBI: begin
                ctrl.alu_op = ALU_OR;
                ctrl.src_b  = SRC_B_IMM;
                imm_ext     = imm8_ext;
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.src_b   = SRC_B_REG;
                ctrl.res_sel = 1'b1;
                ctrl.set_sel = set_sel_e'(opcode[1:0]);
                if (opcode != OP_SCO) begin
                    ctrl.inv_b      = 1'b1;  // Compares look at Rs-Rt
                    ctrl.cin        = 1'b1;
                    ctrl.signed_cmp = 1'b1;
                end
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.pc_sel  = PC_BRANCH;
                ctrl.br_cond = br_cond_e'(opcode[1:0]);
                imm_ext      = imm8_ext;
            end
            OP_J: begin
                ctrl.pc_sel = PC_JUMP;
                imm_ext     = imm11_ext;
            end
            OP_JR: begin
                ctrl.pc_sel = PC_REGISTER;
                ctrl.src_b  = SRC_B_IMM;
                imm_ext     = imm8_ext;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module execute
    import ex_pkg::*;
(
    input  ex_ctrl_t              ctrl,
    input  logic [`EX_DATA_W-1:0] instruction,
    input  logic [`EX_DATA_W-1:0] pc_plus,
    input  logic [`EX_DATA_W-1:0] reg1_data,
    input  logic [`EX_DATA_W-1:0] reg2_data,
    input  logic [`EX_DATA_W-1:0] imm_ext,
    output logic [`EX_DATA_W-1:0] alu_out,
    output logic [`EX_DATA_W-1:0] pc_next,
    output logic                  flush
);

    localparam int W = `EX_DATA_W;
    localparam int HALF = W / 2;

    logic [W-1:0] alu_a;
    logic [W-1:0] alu_b;
    logic [W-1:0] alu_result;
    logic [W-1:0] set_out;
    logic [W-1:0] reg1_rev;
    logic [W-1:0] branch_offset;
    logic [W-1:0] branch_address;
    logic [W-1:0] jump_address;
    logic         alu_z;
    logic         alu_ltz;
    logic         alu_cout;
    logic         sle_lt_zero;

    assign reg1_rev      = {<<{reg1_data}};
    assign branch_offset = {{(W-`EX_IMM8_W){instruction[`EX_IMM8_W-1]}},
                            instruction[`EX_IMM8_W-1:0]};
    assign jump_address  = pc_plus + {{(W-`EX_IMM11_W){instruction[`EX_IMM11_W-1]}},
                                      instruction[`EX_IMM11_W-1:0]};

    always_comb begin
        case (ctrl.src_a)
            SRC_A_SHIFT8: alu_a = {reg1_data[HALF-1:0], imm_ext[HALF-1:0]};
            SRC_A_BITREV: alu_a = reg1_rev;
            default:      alu_a = reg1_data;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            SRC_B_IMM:  alu_b = imm_ext;
            SRC_B_ZERO: alu_b = '0;
            default:    alu_b = reg2_data;
        endcase
    end

    alu i_alu (
        .a           (alu_a),
        .b           (alu_b),
        .cin         (ctrl.cin),
        .inv_a       (ctrl.inv_a),
        .inv_b       (ctrl.inv_b),
        .signed_cmp  (ctrl.signed_cmp),
        .op          (ctrl.alu_op),
        .result      (alu_result),
        .zero        (alu_z),
        .lt_zero     (alu_ltz),
        .cout        (alu_cout),
        .sle_lt_zero (sle_lt_zero)
    );

    branch_control i_branch_control (
        .br_cond        (ctrl.br_cond),
        .branch         (ctrl.pc_sel == PC_BRANCH),
        .alu_z          (alu_z),
        .alu_ltz        (alu_ltz),
        .pc_plus        (pc_plus),
        .branch_offset  (branch_offset),
        .branch_address (branch_address)
    );

    always_comb begin
        case (ctrl.set_sel)
            SET_EQ:  set_out = {{(W-1){1'b0}}, alu_z};
            SET_LT:  set_out = {{(W-1){1'b0}}, sle_lt_zero};
            SET_LE:  set_out = {{(W-1){1'b0}}, sle_lt_zero | alu_z};
            default: set_out = {{(W-1){1'b0}}, alu_cout};
        endcase
    end

    assign alu_out = ctrl.res_sel ? set_out : alu_result;

    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH:   pc_next = branch_address;
            PC_JUMP:     pc_next = jump_address;
            PC_REGISTER: pc_next = alu_out;  // JR target comes out of the adder
            default:     pc_next = pc_plus;
        endcase
    end

    assign flush = (ctrl.pc_sel != PC_SEQUENTIAL);

    // The decoder must never hand over the spare select codes
    a_src_a_legal: assert property (@(ctrl) ctrl.src_a != SRC_A_ILLEGAL)
        else $error("execute: illegal operand A select from decoder");
    a_src_b_legal: assert property (@(ctrl) ctrl.src_b != SRC_B_ILLEGAL)
        else $error("execute: illegal operand B select from decoder");

endmodule

// ==== logic/ex_unit.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_unit
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  issue_pkt_t  in_pkt,
    output logic        in_credit,
    output logic        res_valid,
    output result_pkt_t res_pkt,
    input  logic        res_credit
);

    localparam int W = `EX_DATA_W;
    localparam int DEPTH = `EX_IN_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`EX_OUT_CREDITS + 1);

    issue_pkt_t        buf_mem [DEPTH];
    issue_pkt_t        head;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] out_credits;
    logic              pop;
    ex_ctrl_t          ctrl;
    logic [W-1:0]      imm_ext;
    logic [W-1:0]      alu_out;
    logic [W-1:0]      pc_next;
    logic              flush;

    assign head = buf_mem[rd_ptr];
    assign pop  = (count != '0) && (out_credits != '0);  // Head leaves only with a free slot

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_credits <= CRED_W'(`EX_OUT_CREDITS);
        end else begin
            case ({res_credit, pop})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    instr_decode i_instr_decode (
        .instruction (head.instruction),
        .ctrl        (ctrl),
        .imm_ext     (imm_ext)
    );

    execute i_execute (
        .ctrl        (ctrl),
        .instruction (head.instruction),
        .pc_plus     (head.pc_plus),
        .reg1_data   (head.reg1_data),
        .reg2_data   (head.reg2_data),
        .imm_ext     (imm_ext),
        .alu_out     (alu_out),
        .pc_next     (pc_next),
        .flush       (flush)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            res_valid <= pop;
            in_credit <= pop;  // Freed entry goes back to the sender with the result
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_pkt <= '{alu_out: alu_out, pc_next: pc_next, flush: flush};
        end
    end

    // A full buffer returns its credit one cycle after the pop, so no push may land
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> count != CNT_W'(DEPTH))
        else $error("ex_unit: packet sent into a full issue buffer");

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        res_credit && !pop |-> out_credits < CRED_W'(`EX_OUT_CREDITS))
        else $error("ex_unit: consumer returned more credits than it holds");

endmodule

// ==== sim/ex_clock_gen.sv ====
`timescale 1ns/1ps

module ex_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // Released away from the active edge
    end

endmodule

// ==== sim/tb_ex_unit.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module tb_ex_unit
    import ex_pkg::*;
();

    localparam int DEPTH = `EX_IN_DEPTH;
    localparam int OUT_CREDITS = `EX_OUT_CREDITS;
    localparam int TIMEOUT = 200;
    localparam int RANDOM_CYCLES = 800;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    issue_pkt_t  in_pkt;
    logic        in_credit;
    logic        res_valid;
    result_pkt_t res_pkt;
    logic        res_credit;

    logic [15:0] lfsr_state;
    result_pkt_t exp_q [$];
    int          in_held;
    int          dut_credits;       // Mirror of the DUT output credit counter
    int          held_results;
    int          credit_in_flight;
    int          sent_cnt;
    int          in_credit_cnt;
    int          res_cnt;
    int          credit_policy;     // 0 withhold, 1 random, 2 always return

    ex_opcode_e legal_ops [26] = '{
        OP_NOP, OP_J, OP_JR, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
        OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ, OP_BTR, OP_SLBI, OP_LBI,
        OP_ROL, OP_SLL, OP_ROR, OP_SRL, OP_ADD, OP_SUB, OP_XOR, OP_ANDN,
        OP_SEQ, OP_SLT, OP_SLE, OP_SCO
    };

    ex_clock_gen i_clock_gen (.clk(clk), .arst_n(arst_n));

    ex_unit i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res_pkt    (res_pkt),
        .res_credit (res_credit)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[14:0], next_bit()};
        return v;
    endfunction

    // Expected result straight from the ISA rules
    function automatic result_pkt_t model_result(input issue_pkt_t p);
        ex_opcode_e  op;
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] imm5;
        logic [15:0] imm8;
        logic [15:0] imm11;
        logic [15:0] res;
        logic [15:0] pc;
        logic [16:0] wide;
        logic [3:0]  n;
        logic        fl;
        logic        taken;
        op    = ex_opcode_e'(p.instruction[15:11]);
        rs    = p.reg1_data;
        rt    = p.reg2_data;
        n     = rt[3:0];
        imm5  = {{11{p.instruction[4]}}, p.instruction[4:0]};
        imm8  = {{8{p.instruction[7]}}, p.instruction[7:0]};
        imm11 = {{5{p.instruction[10]}}, p.instruction[10:0]};
        res   = rs;
        pc    = p.pc_plus;
        fl    = 1'b0;
        taken = 1'b0;
        case (op)
            OP_ADD:   res = rs + rt;
            OP_SUB:   res = rt - rs;
            OP_XOR:   res = rs ^ rt;
            OP_ANDN:  res = rs & ~rt;
            OP_ADDI:  res = rs + imm5;
            OP_SUBI:  res = imm5 - rs;
            OP_XORI:  res = rs ^ imm5;
            OP_ANDNI: res = rs & ~imm5;
            OP_ROL:   res = (rs << n) | (rs >> (5'd16 - {1'b0, n}));
            OP_SLL:   res = rs << n;
            OP_ROR:   res = (rs >> n) | (rs << (5'd16 - {1'b0, n}));
            OP_SRL:   res = rs >> n;
            OP_BTR:   for (int i = 0; i < 16; i++) res[i] = rs[15-i];
            OP_SLBI:  res = (rs << 8) | {8'h00, p.instruction[7:0]};
            OP_LBI:   res = imm8;
            OP_SEQ:   res = {15'b0, rs == rt};
            OP_SLT:   res = {15'b0, $signed(rs) < $signed(rt)};
            OP_SLE:   res = {15'b0, $signed(rs) <= $signed(rt)};
            OP_SCO: begin
                wide = {1'b0, rs} + {1'b0, rt};
                res  = {15'b0, wide[16]};
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                case (op)
                    OP_BEQZ: taken = (rs == 16'h0000);
                    OP_BNEZ: taken = (rs != 16'h0000);
                    OP_BLTZ: taken = rs[15];
                    default: taken = !rs[15];
                endcase
                pc = taken ? p.pc_plus + imm8 : p.pc_plus;
                fl = 1'b1;
            end
            OP_J: begin
                pc = p.pc_plus + imm11;
                fl = 1'b1;
            end
            OP_JR: begin
                res = rs + imm8;
                pc  = res;
                fl  = 1'b1;
            end
            default: res = rs;
        endcase
        return '{alu_out: res, pc_next: pc, flush: fl};
    endfunction

    function automatic issue_pkt_t random_pkt();
        issue_pkt_t  p;
        logic [15:0] low;
        int          idx;
        idx = int'(rand_bits(5)) % 26;
        low = rand_bits(11);
        p.instruction = {legal_ops[idx], low[10:0]};
        p.pc_plus     = rand_bits(16);
        p.reg1_data   = rand_bits(16);
        p.reg2_data   = rand_bits(16);
        if (rand_bits(2) == 16'h0000) p.reg1_data = '0;  // Lets zero tests take both ways
        return p;
    endfunction

    function automatic issue_pkt_t directed_pkt(input ex_opcode_e op, input logic [10:0] low,
                                               input logic [15:0] rs, input logic [15:0] rt);
        issue_pkt_t p;
        p.instruction = {op, low};
        p.pc_plus     = 16'h1000;
        p.reg1_data   = rs;
        p.reg2_data   = rt;
        return p;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected) else begin
            $display("error: %s = %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    // One clock: check outputs, settle credits, then drive the next inputs
    task automatic step_cycle(input logic want_send, input issue_pkt_t pkt, output logic sent);
        result_pkt_t exp;
        logic        give;
        @(negedge clk);
        if (res_valid) begin
            assert (dut_credits > 0) else begin
                $display("The DUT sent a result while it held no output credit");
                abort_run();
            end
            assert (exp_q.size() > 0) else begin
                $display("A result appeared with no packet outstanding");
                abort_run();
            end
            exp = exp_q.pop_front();
            check_value("res_pkt.alu_out", res_pkt.alu_out, exp.alu_out);
            check_value("res_pkt.pc_next", res_pkt.pc_next, exp.pc_next);
            check_value("res_pkt.flush", {15'b0, res_pkt.flush}, {15'b0, exp.flush});
            dut_credits--;
            held_results++;
            res_cnt++;
        end
        dut_credits += credit_in_flight;
        if (in_credit) begin
            in_held++;
            in_credit_cnt++;
        end
        assert (in_held <= DEPTH) else begin
            $display("The DUT returned more input credits than packets were sent");
            abort_run();
        end
        sent = want_send && (in_held > 0);
        in_valid = sent;
        if (sent) begin
            in_pkt = pkt;
            in_held--;
            sent_cnt++;
            exp_q.push_back(model_result(pkt));
        end
        give = (held_results > 0) && (credit_policy == 2 || (credit_policy == 1 && next_bit()));
        res_credit = give;
        if (give) held_results--;
        credit_in_flight = give ? 1 : 0;
    endtask

    task automatic send_pkt(input issue_pkt_t pkt);
        logic sent;
        int   waited;
        sent = 1'b0;
        waited = 0;
        while (!sent) begin
            assert (waited < TIMEOUT) else begin
                $display("Timed out waiting for an input credit");
                abort_run();
            end
            step_cycle(1'b1, pkt, sent);
            waited++;
        end
    endtask

    task automatic drain();
        logic sent;
        int   waited;
        credit_policy = 2;
        waited = 0;
        while (exp_q.size() > 0 || in_held != DEPTH || held_results > 0
               || dut_credits != OUT_CREDITS) begin
            assert (waited < TIMEOUT) else begin
                $display("Timed out waiting for outstanding results and credits");
                abort_run();
            end
            step_cycle(1'b0, '0, sent);
            waited++;
        end
    endtask

    task automatic check_latency();
        issue_pkt_t pkt;
        logic       sent;
        pkt = directed_pkt(OP_ADD, 11'h000, 16'h1234, 16'h4321);
        step_cycle(1'b1, pkt, sent);
        assert (sent) else begin
            $display("Packet was not sent although all input credits were free");
            abort_run();
        end
        step_cycle(1'b0, pkt, sent);
        assert (!res_valid) else begin
            $display("Result appeared in the cycle of acceptance");
            abort_run();
        end
        step_cycle(1'b0, pkt, sent);
        assert (res_valid && in_credit) else begin
            $display("Result or input credit missing one cycle after acceptance");
            abort_run();
        end
        drain();
    endtask

    task automatic run_set_extremes();
        logic [15:0] op_a [6];
        logic [15:0] op_b [6];
        ex_opcode_e  set_ops [4];
        op_a = '{16'h8000, 16'h7FFF, 16'h8000, 16'h7FFF, 16'hFFFF, 16'h0000};
        op_b = '{16'h8000, 16'h8000, 16'h7FFF, 16'h7FFF, 16'h0001, 16'hFFFF};
        set_ops = '{OP_SEQ, OP_SLT, OP_SLE, OP_SCO};
        credit_policy = 2;
        foreach (set_ops[k]) begin
            foreach (op_a[j]) send_pkt(directed_pkt(set_ops[k], 11'h000, op_a[j], op_b[j]));
        end
        drain();
    endtask

    task automatic withhold_credits();
        issue_pkt_t pkt;
        logic       sent;
        int         base;
        int         credit_base;
        credit_policy = 0;
        base = res_cnt;
        credit_base = in_credit_cnt;
        repeat (20) begin
            pkt = random_pkt();
            step_cycle(1'b1, pkt, sent);
        end
        assert (res_cnt - base <= OUT_CREDITS) else begin
            $display("More results arrived than the consumer had slots for");
            abort_run();
        end
        // Only the entries popped with the consumer's initial slots may come back
        assert (in_credit_cnt - credit_base == OUT_CREDITS) else begin
            $display("Input credits returned during the stall differ from the entries popped");
            abort_run();
        end
        drain();
    endtask

    initial begin
        int         waited;
        logic       sent;
        issue_pkt_t pkt;
        in_valid = 1'b0;
        in_pkt = '0;
        res_credit = 1'b0;
        lfsr_state = 16'd18;
        in_held = DEPTH;
        dut_credits = OUT_CREDITS;
        held_results = 0;
        credit_in_flight = 0;
        sent_cnt = 0;
        in_credit_cnt = 0;
        res_cnt = 0;
        credit_policy = 2;
        waited = 0;
        while (arst_n !== 1'b1) begin
            assert (waited < TIMEOUT) else begin
                $display("Timed out waiting for reset release");
                abort_run();
            end
            @(posedge clk);
            waited++;
        end
        repeat (5) begin
            step_cycle(1'b0, '0, sent);
            assert (!res_valid && !in_credit) else begin
                $display("Result or input credit raised after reset with no traffic");
                abort_run();
            end
        end
        check_latency();
        run_set_extremes();
        withhold_credits();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (i % 64 == 0) credit_policy = int'(rand_bits(2)) % 3;
            pkt = random_pkt();
            step_cycle(rand_bits(2) != 16'h0000, pkt, sent);
        end
        drain();
        assert (in_credit_cnt == sent_cnt && res_cnt == sent_cnt) else begin
            $display("Credit or result count differs from the packets sent");
            abort_run();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
logic/ex_pkg.sv
logic/alu.sv
logic/branch_control.sv
logic/instr_decode.sv
logic/execute.sv
logic/ex_unit.sv
sim/ex_clock_gen.sv
sim/tb_ex_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ex_unit -f compile.f -o tb_ex_unit

./obj_dir/tb_ex_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
